/* source/i2c_pkg.sv */
`default_nettype none

package i2c_pkg;

  // Register bus
  typedef logic [1:0] reg_addr_t;
  typedef logic [7:0] byte_t;
  typedef logic [6:0] dev_addr_t;

  localparam reg_addr_t ADDR_CTRL = 2'd0;  // Mode register
  localparam reg_addr_t ADDR_STAT = 2'd1;  // Ready and NACK flag
  localparam reg_addr_t ADDR_TX   = 2'd2;  // Write starts a transaction
  localparam reg_addr_t ADDR_RX   = 2'd3;  // Last byte read

  // Bit positions
  localparam int CTRL_READ_BIT  = 0;  // 1 selects a read
  localparam int STAT_NACK_BIT  = 0;  // Missing ACK in last transaction
  localparam int STAT_READY_BIT = 1;  // Master idle

  // Rates
  localparam int SYS_CLK_HZ  = 10_000_000;  // 100 ns system clock
  localparam int I2C_HZ      = 100_000;  // Standard mode
  localparam int QUARTER_DIV = SYS_CLK_HZ / (4 * I2C_HZ);  // 25 cycles per quarter bit

  // Quarter counter sizing
  localparam int QUARTER_CNT_W = $clog2(QUARTER_DIV);
  typedef logic [QUARTER_CNT_W-1:0] quarter_cnt_t;
  localparam quarter_cnt_t QUARTER_LAST = quarter_cnt_t'(QUARTER_DIV - 1);  // Terminal count

  // Master FSM
  typedef enum logic [3:0] {
    IDLE,       // Bus free, SCL high
    START,      // SDA falls while SCL high
    ADDR,       // Seven address bits and mode bit
    ADDR_ACK,   // Target acknowledge of address
    WRITE,      // Data byte out
    WRITE_ACK,  // Target acknowledge of data
    READ,       // Data byte in
    READ_ACK,   // Master answers with NACK
    STOP        // SDA rises while SCL high
  } master_state_t;

endpackage

`default_nettype wire

/* source/i2c_bit_timer.sv */
`timescale 1ns/100ps
`default_nettype none

module i2c_bit_timer (
  input  logic       clk,
  input  logic       rst,
  input  logic       run,      // High while a transaction is active
  output logic       quarter,  // One-cycle strobe per quarter bit
  output logic [1:0] phase     // Quarter index within the bit
);

  i2c_pkg::quarter_cnt_t cnt;  // System cycles within a quarter

  // Strobe on terminal count, cnt is zero whenever run is low
  assign quarter = (cnt == i2c_pkg::QUARTER_LAST);

  always_ff @(posedge clk) begin
    if (rst || !run) begin
      cnt   <= '0;  // Align every transaction to phase 0
      phase <= 2'd0;
    end else if (quarter) begin
      cnt   <= '0;  // Wrap
      phase <= phase + 2'd1;  // Next quarter of the bit
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // The master has to drop run on a quarter boundary
  a_no_quarter_idle: assert property (
    @(posedge clk) disable iff (rst)
    !run |-> !quarter
  ) else $error("quarter strobe while timer stopped");

endmodule

`default_nettype wire

/* source/i2c_master.sv */
`timescale 1ns/100ps
`default_nettype none

module i2c_master (
  input  logic                clk,
  input  logic                rst,
  input  logic                start,     // One-cycle request
  input  logic                rw,        // 1 for read
  input  i2c_pkg::dev_addr_t  dev_addr,
  input  i2c_pkg::byte_t      tx_data,
  input  logic                quarter,   // Quarter-bit strobe
  input  logic [1:0]          phase,
  output logic                run,       // Enables the bit timer
  output logic                busy,
  output logic                done,      // Last cycle of STOP
  output i2c_pkg::byte_t      rx_data,
  output logic                nack,      // Some ACK was missing
  output logic                scl,
  inout  wire                 sda        // Open drain
);

  i2c_pkg::master_state_t state;
  i2c_pkg::byte_t         shift;    // Address, write data or read data
  logic [2:0]             bit_cnt;  // Bits left in current byte, MSB first
  logic                   sda_oe;   // 1 pulls SDA low
  logic                   q_drive;  // Phase 0, SDA may change
  logic                   q_rise;   // Phase 1, SCL rises
  logic                   q_sample; // Phase 2, SDA is stable
  logic                   q_fall;   // Phase 3, SCL falls
  logic                   last_bit;

  assign q_drive  = quarter && (phase == 2'd0);
  assign q_rise   = quarter && (phase == 2'd1);
  assign q_sample = quarter && (phase == 2'd2);
  assign q_fall   = quarter && (phase == 2'd3);
  assign last_bit = (bit_cnt == 3'd0);

  assign sda     = sda_oe ? 1'b0 : 1'bz;  // Release lets the pullup win
  assign busy    = (state != i2c_pkg::IDLE);
  assign run     = busy;
  assign done    = (state == i2c_pkg::STOP) && q_fall;
  assign rx_data = shift;  // Holds the read byte when done

  // Control FSM, SCL and SDA drive
  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= i2c_pkg::IDLE;
      scl     <= 1'b1;  // Bus idle
      sda_oe  <= 1'b0;
      bit_cnt <= 3'd0;
      nack    <= 1'b0;
    end else begin
      if (q_rise) begin
        scl <= 1'b1;
      end
      if (q_fall && state != i2c_pkg::STOP) begin
        scl <= 1'b0;  // STOP leaves SCL high
      end
      case (state)
        i2c_pkg::IDLE: begin
          if (start) begin
            state <= i2c_pkg::START;
            nack  <= 1'b0;  // New transaction
          end
        end
        i2c_pkg::START: begin
          if (q_sample) begin
            sda_oe <= 1'b1;  // SDA low under high SCL
          end
          if (q_fall) begin
            state   <= i2c_pkg::ADDR;
            bit_cnt <= 3'd7;
          end
        end
        i2c_pkg::ADDR, i2c_pkg::WRITE: begin
          if (q_drive) begin
            sda_oe <= ~shift[7];  // Pull low for a zero
          end
          if (q_fall) begin
            if (last_bit) begin
              state <= (state == i2c_pkg::ADDR) ? i2c_pkg::ADDR_ACK : i2c_pkg::WRITE_ACK;
            end else begin
              bit_cnt <= bit_cnt - 3'd1;
            end
          end
        end
        i2c_pkg::ADDR_ACK: begin
          if (q_drive) begin
            sda_oe <= 1'b0;  // Target drives the ACK
          end
          if (q_sample && sda) begin
            nack <= 1'b1;  // No target answered
          end
          if (q_fall) begin
            bit_cnt <= 3'd7;
            if (nack) begin
              state <= i2c_pkg::STOP;  // Abandon after address NACK
            end else if (rw) begin
              state <= i2c_pkg::READ;
            end else begin
              state <= i2c_pkg::WRITE;
            end
          end
        end
        i2c_pkg::WRITE_ACK: begin
          if (q_drive) begin
            sda_oe <= 1'b0;
          end
          if (q_sample && sda) begin
            nack <= 1'b1;  // Data byte refused
          end
          if (q_fall) begin
            state <= i2c_pkg::STOP;
          end
        end
        i2c_pkg::READ: begin
          if (q_drive) begin
            sda_oe <= 1'b0;  // Target owns SDA
          end
          if (q_fall) begin
            if (last_bit) begin
              state <= i2c_pkg::READ_ACK;
            end else begin
              bit_cnt <= bit_cnt - 3'd1;
            end
          end
        end
        i2c_pkg::READ_ACK: begin
          if (q_drive) begin
            sda_oe <= 1'b0;  // NACK, single byte read
          end
          if (q_fall) begin
            state <= i2c_pkg::STOP;
          end
        end
        i2c_pkg::STOP: begin
          if (q_drive) begin
            sda_oe <= 1'b1;  // SDA low before SCL rises
          end
          if (q_sample) begin
            sda_oe <= 1'b0;  // SDA rises under high SCL
          end
          if (q_fall) begin
            state <= i2c_pkg::IDLE;
          end
        end
        default: state <= i2c_pkg::IDLE;
      endcase
    end
  end

  // Shift register, MSB first in both directions
  always_ff @(posedge clk) begin
    if (state == i2c_pkg::IDLE && start) begin
      shift <= {dev_addr, rw};  // Address byte
    end else if (state == i2c_pkg::ADDR_ACK && q_fall) begin
      shift <= tx_data;
    end else if ((state == i2c_pkg::ADDR || state == i2c_pkg::WRITE) && q_fall) begin
      shift <= {shift[6:0], 1'b0};
    end else if (state == i2c_pkg::READ && q_sample) begin
      shift <= {shift[6:0], sda};  // Sample at mid-high SCL
    end
  end

  // Register map must hold off requests
  a_start_idle: assert property (
    @(posedge clk) disable iff (rst)
    start |-> !busy
  ) else $error("start while busy");

  // STOP leaves both lines high
  a_done_bus_idle: assert property (
    @(posedge clk) disable iff (rst)
    done |-> (scl && sda)
  ) else $error("done without an idle bus");

  a_scl_idle: assert property (
    @(posedge clk) disable iff (rst)
    (state == i2c_pkg::IDLE) |-> scl
  ) else $error("SCL low while idle");

endmodule

`default_nettype wire

/* source/i2c_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module i2c_regs (
  input  logic               clk,
  input  logic               rst,
  input  i2c_pkg::reg_addr_t addr,
  input  logic               wr_en,     // Write strobe, no handshake
  input  i2c_pkg::byte_t     data_in,
  output i2c_pkg::byte_t     data_out,  // Combinational read data
  input  logic               busy,
  input  logic               done,
  input  i2c_pkg::byte_t     rx_data,
  input  logic               nack,
  output logic               start,     // One-cycle request to master
  output logic               rw,        // CTRL mode bit
  output i2c_pkg::byte_t     tx_data
);

  i2c_pkg::byte_t rx_reg;     // RX register
  logic           nack_flag;  // Sticky until next done
  logic           idle;       // Free to accept a new request
  logic           tx_wr;

  assign idle  = !busy && !start;  // Start cycle counts as busy
  assign tx_wr = wr_en && (addr == i2c_pkg::ADDR_TX) && idle;

  always_ff @(posedge clk) begin
    if (rst) begin
      start     <= 1'b0;
      rw        <= 1'b0;
      rx_reg    <= '0;
      nack_flag <= 1'b0;
    end else begin
      start <= tx_wr;  // Dropped while busy
      if (wr_en && addr == i2c_pkg::ADDR_CTRL && idle) begin
        rw <= data_in[i2c_pkg::CTRL_READ_BIT];  // Mode held for the transaction
      end
      if (done) begin
        nack_flag <= nack;
        if (rw && !nack) begin
          rx_reg <= rx_data;  // Only when the target answered
        end
      end
    end
  end

  // TX payload
  always_ff @(posedge clk) begin
    if (tx_wr) begin
      tx_data <= data_in;
    end
  end

  // Read mux
  always_comb begin
    data_out = '0;
    case (addr)
      i2c_pkg::ADDR_CTRL: data_out[i2c_pkg::CTRL_READ_BIT] = rw;
      i2c_pkg::ADDR_STAT: begin
        data_out[i2c_pkg::STAT_READY_BIT] = idle;
        data_out[i2c_pkg::STAT_NACK_BIT]  = nack_flag;
      end
      i2c_pkg::ADDR_TX:   data_out = '0;  // Write only
      i2c_pkg::ADDR_RX:   data_out = rx_reg;
      default:            data_out = '0;
    endcase
  end

  // Master picks up every request
  a_start_taken: assert property (
    @(posedge clk) disable iff (rst)
    start |=> busy
  ) else $error("start not taken by the master");

endmodule

`default_nettype wire

/* source/i2c_top.sv */
`timescale 1ns/100ps
`default_nettype none

module i2c_top (
  input  logic               clk,
  input  logic               rst,
  input  i2c_pkg::reg_addr_t addr,
  input  i2c_pkg::dev_addr_t dev_addr,  // Target address
  input  logic               wr_en,
  input  i2c_pkg::byte_t     data_in,
  output i2c_pkg::byte_t     data_out,
  output logic               scl_pin,   // Push-pull SCL
  inout  wire                sda_pin    // Needs external pullup
);

  logic           start;  // Regs to master
  logic           rw;
  i2c_pkg::byte_t tx_data;
  logic           busy;   // Master to regs
  logic           done;
  logic           nack;
  i2c_pkg::byte_t rx_data;
  logic           run;    // Master to timer
  logic           quarter;
  logic [1:0]     phase;

  i2c_regs u_regs (
    .clk      (clk),
    .rst      (rst),
    .addr     (addr),
    .wr_en    (wr_en),
    .data_in  (data_in),
    .data_out (data_out),
    .busy     (busy),
    .done     (done),
    .rx_data  (rx_data),
    .nack     (nack),
    .start    (start),
    .rw       (rw),
    .tx_data  (tx_data)
  );

  i2c_master u_master (
    .clk      (clk),
    .rst      (rst),
    .start    (start),
    .rw       (rw),
    .dev_addr (dev_addr),
    .tx_data  (tx_data),
    .quarter  (quarter),
    .phase    (phase),
    .run      (run),
    .busy     (busy),
    .done     (done),
    .rx_data  (rx_data),
    .nack     (nack),
    .scl      (scl_pin),
    .sda      (sda_pin)
  );

  i2c_bit_timer u_timer (
    .clk     (clk),
    .rst     (rst),
    .run     (run),
    .quarter (quarter),
    .phase   (phase)
  );

endmodule

`default_nettype wire

/* verification/i2c_slave_model.sv */
`timescale 1ns/100ps
`default_nettype none

module i2c_slave_model (
  input  logic               clk,       // Oversamples SCL and SDA
  input  logic               rst,
  input  i2c_pkg::dev_addr_t own_addr,  // Only address that gets an ACK
  input  logic               scl,
  inout  wire                sda,       // Open drain, pullup in testbench
  output i2c_pkg::byte_t     stored     // Last byte written by the master
);

  typedef enum logic [2:0] {
    IDLE,       // Not addressed, waits for START
    ADDR,       // Address and mode bit in
    ADDR_ACK,   // Holds SDA low for the ACK
    WRITE,      // Data byte in
    WRITE_ACK,  // ACK of data byte
    READ,       // Reply byte out
    READ_ACK    // Master answers, always NACK here
  } target_state_t;

  target_state_t  state;
  i2c_pkg::byte_t shreg;       // Incoming bits or outgoing reply
  i2c_pkg::byte_t reply;       // Read data, inverse of stored byte
  logic [3:0]     cnt;         // Bits moved in current byte
  logic           rw;          // Mode bit of a matched address
  logic           sda_low;     // 1 pulls SDA low
  logic           scl_q;       // Bus values one clock back
  logic           sda_q;
  logic           scl_rise;
  logic           scl_fall;
  logic           start_cond;
  logic           stop_cond;

  assign sda        = sda_low ? 1'b0 : 1'bz;
  assign reply      = ~stored;
  assign scl_rise   = scl && !scl_q;
  assign scl_fall   = !scl && scl_q;
  assign start_cond = scl && scl_q && sda_q && !sda;  // SDA falls under high SCL
  assign stop_cond  = scl && scl_q && !sda_q && sda;  // SDA rises under high SCL

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= IDLE;
      shreg   <= '0;
      stored  <= '0;
      cnt     <= 4'd0;
      rw      <= 1'b0;
      sda_low <= 1'b0;
      scl_q   <= 1'b1;  // Idle bus
      sda_q   <= 1'b1;
    end else begin
      scl_q <= scl;
      sda_q <= sda;
      if (start_cond) begin
        state   <= ADDR;
        cnt     <= 4'd0;
        sda_low <= 1'b0;
      end else if (stop_cond) begin
        state   <= IDLE;
        sda_low <= 1'b0;
      end else begin
        case (state)
          ADDR, WRITE: begin
            if (scl_rise) begin
              shreg <= {shreg[6:0], sda};  // MSB first
              cnt   <= cnt + 4'd1;
            end else if (scl_fall && cnt == 4'd8) begin
              if (state == WRITE) begin
                stored  <= shreg;
                sda_low <= 1'b1;  // ACK the data
                state   <= WRITE_ACK;
              end else if (shreg[7:1] == own_addr) begin
                rw      <= shreg[0];
                sda_low <= 1'b1;  // ACK the address
                state   <= ADDR_ACK;
              end else begin
                state <= IDLE;  // Someone else, stay off the bus
              end
            end
          end
          ADDR_ACK: begin
            if (scl_fall) begin
              if (rw) begin
                sda_low <= !reply[7];  // First reply bit
                shreg   <= {reply[6:0], 1'b0};
                cnt     <= 4'd1;
                state   <= READ;
              end else begin
                sda_low <= 1'b0;
                cnt     <= 4'd0;
                state   <= WRITE;
              end
            end
          end
          WRITE_ACK: begin
            if (scl_fall) begin
              sda_low <= 1'b0;
              state   <= IDLE;
            end
          end
          READ: begin
            if (scl_fall) begin
              if (cnt == 4'd8) begin
                sda_low <= 1'b0;  // Hand SDA back for the NACK
                state   <= READ_ACK;
              end else begin
                sda_low <= !shreg[7];
                shreg   <= {shreg[6:0], 1'b0};
                cnt     <= cnt + 4'd1;
              end
            end
          end
          READ_ACK: begin
            if (scl_fall) begin
              state <= IDLE;
            end
          end
          default: state <= IDLE;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* verification/i2c_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module i2c_tb;

  localparam i2c_pkg::dev_addr_t GOOD_ADDR = 7'h2a;  // Answered by the model
  localparam i2c_pkg::dev_addr_t BAD_ADDR  = 7'h15;  // Nobody home
  localparam int NUM_TXN    = 10;  // Bus transactions over all tests
  localparam int TXN_CYCLES = 22 * 4 * i2c_pkg::QUARTER_DIV;  // 20 bits plus polling slack
  localparam int TIMEOUT_CYCLES = ((NUM_TXN * TXN_CYCLES) / 10_000 + 1) * 10_000;

  logic               clk;
  logic               rst;
  i2c_pkg::reg_addr_t addr;
  i2c_pkg::dev_addr_t dev_addr;
  logic               wr_en;
  i2c_pkg::byte_t     data_in;
  i2c_pkg::byte_t     data_out;
  logic               scl_pin;
  wire                sda_pin;
  i2c_pkg::byte_t     model_byte;  // Byte held by the target model

  logic [31:0]    lfsr;
  i2c_pkg::byte_t model_ref;  // Expected target byte
  i2c_pkg::byte_t rx_ref;     // Expected RX register
  int             errors;
  int             checks;

  pullup (sda_pin);

  i2c_top dut (
    .clk      (clk),
    .rst      (rst),
    .addr     (addr),
    .dev_addr (dev_addr),
    .wr_en    (wr_en),
    .data_in  (data_in),
    .data_out (data_out),
    .scl_pin  (scl_pin),
    .sda_pin  (sda_pin)
  );

  i2c_slave_model target (
    .clk      (clk),
    .rst      (rst),
    .own_addr (GOOD_ADDR),
    .scl      (scl_pin),
    .sda      (sda_pin),
    .stored   (model_byte)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Wrong address gives NACK, a write stores, a read returns the inverse
  function automatic logic predict_result(input i2c_pkg::dev_addr_t target_addr,
      input logic rd, input i2c_pkg::byte_t data,
      inout i2c_pkg::byte_t stored_exp, inout i2c_pkg::byte_t rx_exp);
    if (target_addr != GOOD_ADDR) begin
      return 1'b1;  // RX and target untouched
    end
    if (rd) begin
      rx_exp = ~stored_exp;
    end else begin
      stored_exp = data;
    end
    return 1'b0;
  endfunction

  function automatic i2c_pkg::byte_t ctrl_byte(input logic rd);
    i2c_pkg::byte_t b;
    b = '0;
    b[i2c_pkg::CTRL_READ_BIT] = rd;
    return b;
  endfunction

  task automatic draw_byte(output i2c_pkg::byte_t b);
    b = '0;
    for (int i = 0; i < 8; i++) begin
      lfsr = lfsr_next(lfsr);  // One step per bit
      b = {b[6:0], lfsr[0]};
    end
  endtask

  task automatic check_byte(input string name, input i2c_pkg::byte_t got,
      input i2c_pkg::byte_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got 0x%02h, expected 0x%02h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic write_reg(input i2c_pkg::reg_addr_t a, input i2c_pkg::byte_t d);
    @(negedge clk);
    addr    = a;
    data_in = d;
    wr_en   = 1'b1;
    @(negedge clk);
    wr_en   = 1'b0;  // Single write strobe
  endtask

  task automatic read_reg(input i2c_pkg::reg_addr_t a, output i2c_pkg::byte_t d);
    @(negedge clk);
    addr = a;
    @(negedge clk);
    d = data_out;  // Settled since the last rising edge
  endtask

  task automatic wait_ready(output i2c_pkg::byte_t stat);
    stat = '0;
    while (!stat[i2c_pkg::STAT_READY_BIT]) begin
      read_reg(i2c_pkg::ADDR_STAT, stat);
    end
  endtask

  task automatic do_transfer(input i2c_pkg::dev_addr_t target_addr, input logic rd,
      input i2c_pkg::byte_t data);
    logic           nack_exp;
    i2c_pkg::byte_t stat;
    i2c_pkg::byte_t rx;
    nack_exp = predict_result(target_addr, rd, data, model_ref, rx_ref);
    @(negedge clk);
    dev_addr = target_addr;
    write_reg(i2c_pkg::ADDR_CTRL, ctrl_byte(rd));
    write_reg(i2c_pkg::ADDR_TX, data);  // Kicks off the transaction
    wait_ready(stat);
    check_flag("stat.nack", stat[i2c_pkg::STAT_NACK_BIT], nack_exp);
    check_flag("scl_pin", scl_pin, 1'b1);  // STOP leaves the bus idle
    check_flag("sda_pin", sda_pin, 1'b1);
    read_reg(i2c_pkg::ADDR_RX, rx);
    check_byte("rx", rx, rx_ref);
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: FAILED with %0d errors", name, errors - errors_before);
    end
  endtask

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, the master never returned to ready", cycles);
    $display("Done: errors found");
    $finish;
  end

  initial begin : main
    int             e0;
    i2c_pkg::byte_t b;
    i2c_pkg::byte_t first;
    i2c_pkg::byte_t stat;
    rst       = 1'b1;
    addr      = i2c_pkg::ADDR_CTRL;
    dev_addr  = '0;
    wr_en     = 1'b0;
    data_in   = '0;
    lfsr      = 32'h46c0;
    model_ref = '0;  // Target and RX both clear after reset
    rx_ref    = '0;
    errors    = 0;
    checks    = 0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    e0 = errors;
    read_reg(i2c_pkg::ADDR_STAT, stat);
    check_flag("stat.ready", stat[i2c_pkg::STAT_READY_BIT], 1'b1);
    check_flag("stat.nack", stat[i2c_pkg::STAT_NACK_BIT], 1'b0);
    read_reg(i2c_pkg::ADDR_RX, b);
    check_byte("rx", b, '0);
    check_flag("scl_pin", scl_pin, 1'b1);  // Bus idle out of reset
    check_flag("sda_pin", sda_pin, 1'b1);
    report_test("reset state", e0);

    e0 = errors;
    draw_byte(b);
    do_transfer(GOOD_ADDR, 1'b0, b);
    check_byte("model.stored", model_byte, model_ref);
    report_test("single write", e0);

    e0 = errors;
    for (int i = 0; i < 3; i++) begin
      draw_byte(b);
      do_transfer(GOOD_ADDR, 1'b0, b);
      check_byte("model.stored", model_byte, model_ref);
      do_transfer(GOOD_ADDR, 1'b1, 8'h00);  // TX value unused on reads
    end
    report_test("write then read", e0);

    e0 = errors;
    draw_byte(b);
    do_transfer(BAD_ADDR, 1'b0, b);
    check_byte("model.stored", model_byte, model_ref);
    draw_byte(b);
    do_transfer(GOOD_ADDR, 1'b0, b);  // Clears the sticky flag
    report_test("address nack", e0);

    e0 = errors;
    draw_byte(first);
    draw_byte(b);
    if (b == first) begin
      b = ~first;  // Second byte has to differ
    end
    void'(predict_result(GOOD_ADDR, 1'b0, first, model_ref, rx_ref));
    @(negedge clk);
    dev_addr = GOOD_ADDR;
    write_reg(i2c_pkg::ADDR_CTRL, ctrl_byte(1'b0));
    write_reg(i2c_pkg::ADDR_TX, first);
    read_reg(i2c_pkg::ADDR_STAT, stat);
    check_flag("stat.ready", stat[i2c_pkg::STAT_READY_BIT], 1'b0);
    write_reg(i2c_pkg::ADDR_TX, b);  // Master busy, dropped
    wait_ready(stat);
    check_flag("stat.nack", stat[i2c_pkg::STAT_NACK_BIT], 1'b0);
    check_byte("model.stored", model_byte, model_ref);
    report_test("write while busy", e0);

    e0 = errors;
    write_reg(i2c_pkg::ADDR_CTRL, ctrl_byte(1'b1));
    read_reg(i2c_pkg::ADDR_CTRL, b);
    check_byte("ctrl", b, ctrl_byte(1'b1));
    write_reg(i2c_pkg::ADDR_CTRL, ctrl_byte(1'b0));
    read_reg(i2c_pkg::ADDR_CTRL, b);
    check_byte("ctrl", b, ctrl_byte(1'b0));
    read_reg(i2c_pkg::ADDR_TX, b);
    check_byte("tx", b, '0);
    report_test("register readback", e0);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
source/i2c_pkg.sv
source/i2c_bit_timer.sv
source/i2c_master.sv
source/i2c_regs.sv
source/i2c_top.sv
verification/i2c_slave_model.sv
verification/i2c_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the I2C master testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module i2c_tb \
  --Mdir obj_dir -o i2c_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/i2c_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Done: no errors" sim.log; then
  echo "PASS"
  exit 0
fi

echo "FAIL"
exit 1
